// File: barrett_pkg.sv
`default_nettype none

package barrett_pkg;

  localparam int unsigned MOD_W  = 16;         // Modulus and result width.
  localparam int unsigned X_W    = 2 * MOD_W;  // Operand and mu width.
  localparam int unsigned PROD_W = 2 * X_W;    // Full product width.
  localparam int unsigned HALF_W = X_W / 2;    // Partial product operand width.
  localparam int unsigned K_W    = 5;          // Holds bit length up to MOD_W.
  localparam int unsigned TAG_W  = 4;

  localparam int unsigned MUL_LAT    = 3;
  localparam int unsigned X_DLY      = 2 * MUL_LAT + 1;  // Input reg to subtraction.
  localparam int unsigned VT_DLY     = 2 * MUL_LAT + 2;  // Input reg to output reg.
  localparam int unsigned REDUCE_LAT = 2 * MUL_LAT + 4;
  localparam int unsigned CNT_W      = $clog2(REDUCE_LAT + 1);

  typedef logic [TAG_W-1:0] tag_t;

  typedef struct packed {
    logic [MOD_W-1:0] q;
    logic [X_W-1:0]   mu;  // floor(4^k / q), computed by the host.
  } cfg_wr_t;

  typedef struct packed {
    logic [MOD_W-1:0] q;
    logic [X_W-1:0]   mu;
    logic [K_W-1:0]   k;   // Bit length of q.
  } barrett_cfg_t;

  typedef struct packed {
    logic [X_W-1:0] x;
    tag_t           tag;
  } red_in_t;

  typedef struct packed {
    logic [MOD_W-1:0] r;
    tag_t             tag;
  } red_out_t;

endpackage

`default_nettype wire

// File: pipe_mult.sv
`default_nettype none

module pipe_mult (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [barrett_pkg::X_W-1:0]    a_i,
  input  logic [barrett_pkg::X_W-1:0]    b_i,
  output logic [barrett_pkg::PROD_W-1:0] p_o
);
  import barrett_pkg::*;

  logic [X_W-1:0] a_q;
  logic [X_W-1:0] b_q;
  logic [X_W-1:0] pp_ll_q;  // a low times b low.
  logic [X_W-1:0] pp_lh_q;  // a low times b high.
  logic [X_W-1:0] pp_hl_q;  // a high times b low.
  logic [X_W-1:0] pp_hh_q;  // a high times b high.

  // Operand capture in stage 1.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= a_i;
      b_q <= b_i;
    end
  end

  // Four half-width partial products in stage 2.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pp_ll_q <= '0;
      pp_lh_q <= '0;
      pp_hl_q <= '0;
      pp_hh_q <= '0;
    end else begin
      pp_ll_q <= X_W'(a_q[HALF_W-1:0]) * X_W'(b_q[HALF_W-1:0]);
      pp_lh_q <= X_W'(a_q[HALF_W-1:0]) * X_W'(b_q[X_W-1:HALF_W]);
      pp_hl_q <= X_W'(a_q[X_W-1:HALF_W]) * X_W'(b_q[HALF_W-1:0]);
      pp_hh_q <= X_W'(a_q[X_W-1:HALF_W]) * X_W'(b_q[X_W-1:HALF_W]);
    end
  end

  // Sum in stage 3. The outer products do not overlap and simply concatenate.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      p_o <= '0;
    end else begin
      p_o <= {pp_hh_q, pp_ll_q}
           + (PROD_W'(pp_lh_q) << HALF_W)   // Cross terms.
           + (PROD_W'(pp_hl_q) << HALF_W);
    end
  end

endmodule

`default_nettype wire

// File: delay_line.sv
`default_nettype none

module delay_line #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 1
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     d_i,
  output T     d_o
);

  T stage_q [DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];  // Shift one slot per cycle.
      end
    end
  end

  assign d_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: barrett_cfg.sv
`default_nettype none

module barrett_cfg (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      cfg_we_i,
  input  barrett_pkg::cfg_wr_t      cfg_i,
  output barrett_pkg::barrett_cfg_t cfg_o,
  output logic                      cfg_we_o
);
  import barrett_pkg::*;

  logic [K_W-1:0] k_calc;

  // Leading-one search, k is the index of the top set bit plus one.
  always_comb begin
    k_calc = '0;
    for (int unsigned i = 0; i < MOD_W; i++) begin
      if (cfg_i.q[i]) begin
        k_calc = K_W'(i + 1);  // Higher bits overwrite lower.
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_o    <= '0;
      cfg_we_o <= 1'b0;
    end else begin
      cfg_we_o <= cfg_we_i;  // Update marker for the pipeline.
      if (cfg_we_i) begin
        cfg_o.q  <= cfg_i.q;
        cfg_o.mu <= cfg_i.mu;
        cfg_o.k  <= k_calc;
      end
    end
  end

  // Barrett needs a modulus of at least two.
  a_q_min: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_we_i |-> cfg_i.q >= MOD_W'(2));

endmodule

`default_nettype wire

// File: barrett_reduce.sv
`default_nettype none

module barrett_reduce (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  barrett_pkg::barrett_cfg_t cfg_i,
  input  logic                      cfg_we_i,
  input  logic                      in_valid_i,
  input  barrett_pkg::red_in_t      in_i,
  output logic                      out_valid_o,
  output barrett_pkg::red_out_t     out_o
);
  import barrett_pkg::*;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } vt_t;

  logic              in_valid_q;
  red_in_t           in_q;
  vt_t               vt_in;
  vt_t               vt_dly;
  logic [X_W-1:0]    x_dly;
  logic [PROD_W-1:0] xmu;
  logic [X_W-1:0]    qhat_q;
  logic [PROD_W-1:0] qhq;
  logic [X_W-1:0]    r_q;
  logic [X_W-1:0]    r_one;
  logic [X_W-1:0]    r_two;
  logic [X_W-1:0]    q_ext;
  logic [K_W:0]      shamt;
  logic [CNT_W-1:0]  inflight_q;

  assign q_ext = X_W'(cfg_i.q);
  assign shamt = {cfg_i.k, 1'b0};  // Shift by 2k.
  assign vt_in = '{valid: in_valid_q, tag: in_q.tag};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    in_q <= in_i;
  end

  // x times mu.
  pipe_mult mult_xmu_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .a_i    (in_q.x),
    .b_i    (cfg_i.mu),
    .p_o    (xmu)
  );

  always_ff @(posedge clk_i) begin
    qhat_q <= X_W'(xmu >> shamt);  // Estimate stays below q.
  end

  // qhat times q.
  pipe_mult mult_qhq_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .a_i    (qhat_q),
    .b_i    (q_ext),
    .p_o    (qhq)
  );

  delay_line #(
    .T     (logic [X_W-1:0]),
    .DEPTH (X_DLY)
  ) x_dly_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (in_q.x),
    .d_o    (x_dly)
  );

  delay_line #(
    .T     (vt_t),
    .DEPTH (VT_DLY)
  ) vt_dly_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (vt_in),
    .d_o    (vt_dly)
  );

  always_ff @(posedge clk_i) begin
    r_q <= x_dly - qhq[X_W-1:0];  // Exact, true value is below 3q.
  end

  // Estimate may be short by up to 2q.
  assign r_one = (r_q >= q_ext) ? r_q - q_ext : r_q;
  assign r_two = (r_one >= q_ext) ? r_one - q_ext : r_one;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
      out_o       <= '0;
    end else begin
      out_valid_o <= vt_dly.valid;
      if (vt_dly.valid) begin
        out_o.r   <= r_two[MOD_W-1:0];
        out_o.tag <= vt_dly.tag;
      end
    end
  end

  // Operands between input and output register.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + CNT_W'(in_valid_i) - CNT_W'(vt_dly.valid);
    end
  end

  a_x_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_i |-> in_i.x < q_ext * q_ext);

  a_cfg_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_we_i |-> inflight_q == '0);

  a_r_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o |-> out_o.r < cfg_i.q);

endmodule

`default_nettype wire

// File: barrett_top.sv
`default_nettype none

module barrett_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,
  input  barrett_pkg::cfg_wr_t  cfg_i,
  input  logic                  in_valid_i,
  input  barrett_pkg::red_in_t  in_i,
  output logic                  out_valid_o,
  output barrett_pkg::red_out_t out_o
);
  import barrett_pkg::*;

  barrett_cfg_t cfg;
  logic         cfg_upd;  // One cycle after a write.

  barrett_cfg barrett_cfg_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cfg_we_i (cfg_we_i),
    .cfg_i    (cfg_i),
    .cfg_o    (cfg),
    .cfg_we_o (cfg_upd)
  );

  barrett_reduce barrett_reduce_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg),
    .cfg_we_i    (cfg_upd),
    .in_valid_i  (in_valid_i),
    .in_i        (in_i),
    .out_valid_o (out_valid_o),
    .out_o       (out_o)
  );

endmodule

`default_nettype wire

// File: tb_barrett.sv
`default_nettype none

module tb_barrett;
  timeunit 1ns;
  timeprecision 1ns;
  import barrett_pkg::*;

  localparam int unsigned RST_CYCLES  = 5;
  localparam int unsigned IDLE_CYCLES = 20;
  localparam int unsigned N_STREAM    = 200;
  localparam int unsigned N_EDGE      = 8;
  localparam int unsigned N_RECFG     = 40;
  localparam int unsigned STIM_CYCLES = RST_CYCLES + IDLE_CYCLES + 4 * 2 + 1 + N_STREAM
                                      + N_EDGE + 3 * N_RECFG + 6 * (REDUCE_LAT + 3);
  localparam int unsigned TIMEOUT_CYCLES = 2 * STIM_CYCLES + REDUCE_LAT;

  logic     clk_i;
  logic     rst_ni;
  logic     cfg_we_i;
  cfg_wr_t  cfg_i;
  logic     in_valid_i;
  red_in_t  in_i;
  logic     out_valid_o;
  red_out_t out_o;

  logic [15:0]      lfsr = 16'd21039;
  logic [MOD_W-1:0] cur_q;
  tag_t             next_tag;
  int unsigned      cyc = 0;
  int unsigned      n_checks = 0;
  int unsigned      err_cnt = 0;
  int unsigned      err_mark = 0;
  red_out_t         exp_q [$];
  int unsigned      stamp_q [$];
  red_out_t         req_exp;
  red_out_t         exp_r;
  red_out_t         zero_out;
  logic             exp_valid;

  barrett_top barrett_top_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_i       (cfg_i),
    .in_valid_i  (in_valid_i),
    .in_i        (in_i),
    .out_valid_o (out_valid_o),
    .out_o       (out_o)
  );

  always #50 clk_i = ~clk_i;

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [X_W-1:0] rand_bits(input int n);
    logic [X_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[X_W-2:0], lfsr[0]};  // One step per bit.
    end
    return v;
  endfunction

  function automatic logic [MOD_W-1:0] ref_mod(input logic [X_W-1:0] x,
                                               input logic [MOD_W-1:0] q);
    return MOD_W'(x % X_W'(q));
  endfunction

  // mu = floor(4^k / q), k is the bit length of q.
  function automatic logic [X_W-1:0] calc_mu(input logic [MOD_W-1:0] q);
    int k;
    k = 0;
    for (int i = 0; i < MOD_W; i++) begin
      if (q[i]) k = i + 1;
    end
    return X_W'((64'd1 << (2 * k)) / 64'(q));
  endfunction

  function automatic logic [X_W-1:0] rand_below_q2();
    logic [63:0] q2;
    q2 = 64'(cur_q) * 64'(cur_q);
    return X_W'(64'(rand_bits(X_W)) % q2);
  endfunction

  task automatic check_result(input red_out_t got, input red_out_t exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: result r=%0d tag=%0d, expected r=%0d tag=%0d",
               $time, got.r, got.tag, exp.r, exp.tag);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: out_valid_o=%b, expected %b", $time, got, exp);
    end
  endtask

  task automatic configure(input logic [MOD_W-1:0] q);
    @(posedge clk_i);
    cfg_we_i <= 1'b1;
    cfg_i    <= '{q: q, mu: calc_mu(q)};
    cur_q = q;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
  endtask

  task automatic send(input logic [X_W-1:0] x);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    in_i       <= '{x: x, tag: next_tag};
    next_tag = next_tag + tag_t'(1);
  endtask

  // Idle the input, then wait for every pending result.
  task automatic drain();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
  endtask

  task automatic report_test(input string name);
    $display("Test %-8s done, %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // Cycle counter and watchdog.
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d results never arrived", cyc, exp_q.size());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Request monitor, records expected result and issue cycle.
  always @(negedge clk_i) begin
    if (rst_ni && in_valid_i) begin
      req_exp.r   = ref_mod(in_i.x, cur_q);
      req_exp.tag = in_i.tag;
      exp_q.push_back(req_exp);
      stamp_q.push_back(cyc);
    end
  end

  // Compare, a result is due exactly REDUCE_LAT cycles after its request.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      exp_valid = (stamp_q.size() != 0) && (stamp_q[0] + REDUCE_LAT == cyc);
      check_valid(out_valid_o, exp_valid);
      if (exp_valid) begin
        void'(stamp_q.pop_front());
        exp_r = exp_q.pop_front();
        if (out_valid_o) check_result(out_o, exp_r);
      end
    end
  end

  initial begin
    logic [X_W-1:0] q32;
    logic [MOD_W-1:0] moduli [3];
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    cfg_we_i   = 1'b0;
    cfg_i      = '0;
    in_valid_i = 1'b0;
    in_i       = '0;
    cur_q      = '0;
    next_tag   = '0;
    zero_out   = '0;
    moduli     = '{16'd3, 16'd256, 16'd40961};

    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_result(out_o, zero_out);
    repeat (IDLE_CYCLES) @(posedge clk_i);  // Compare process watches out_valid_o.
    report_test("reset");

    configure(16'd65521);
    send(rand_below_q2());
    drain();
    report_test("single");

    for (int i = 0; i < N_STREAM; i++) begin
      send(rand_below_q2());
    end
    drain();
    report_test("stream");

    q32 = X_W'(cur_q);
    send('0);
    send(q32 - 1);
    send(q32);
    send(2 * q32 - 1);
    send(q32 * q32 - q32 - 1);  // Just below a multiple, largest shortfall.
    send(q32 * q32 - q32);
    send(q32 * q32 - 2);
    send(q32 * q32 - 1);
    drain();
    report_test("edge");

    foreach (moduli[m]) begin
      configure(moduli[m]);
      for (int i = 0; i < N_RECFG; i++) begin
        send(rand_below_q2());
      end
      drain();
    end
    report_test("reconfig");

    $display("Checks: %0d, errors: %0d", n_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
barrett_pkg.sv
pipe_mult.sv
delay_line.sv
barrett_cfg.sv
barrett_reduce.sv
barrett_top.sv
tb_barrett.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Barrett testbench with Verilator.
# Exit status is nonzero unless the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_barrett \
  && ./obj_dir/Vtb_barrett | tee /dev/stderr | grep -q "RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
